/* design/neo_defines.svh */
`ifndef NEO_DEFINES_SVH
`define NEO_DEFINES_SVH

// Word address width covering byte address bits 23 down to 1
`define NEO_ADDR_W 23

// Palette index width inside one bank
`define NEO_PAL_IDX_W 12

// Address bits 23 to 17 for the system latch at 0x3A0000
`define NEO_LATCH_BASE 7'h1D

// Address bits 23 to 22 for palette RAM at 0x400000 to 0x7FFFFF
// Palette mirrors every 8 KB
`define NEO_PAL_HI 2'b01

// Value seen on reads of the latch or unmapped space
`define NEO_OPEN_BUS 16'hFFFF

`endif

/* design/neo_pkg.sv */
`default_nettype none

`include "neo_defines.svh"

package neoPkg;

	// One CPU bus cycle as seen at the request strobe
	typedef struct packed {
		logic [`NEO_ADDR_W:1] addr;
		logic [15:0]          wrData;
		// High for read
		logic                 rw;
		logic                 uppEn;
		logic                 lowEn;
	} cpuBusT;

	// Decoded view of a palette word
	typedef struct packed {
		logic       dark;
		logic       rLsb;
		logic       gLsb;
		logic       bLsb;
		logic [3:0] rMsb;
		logic [3:0] gMsb;
		logic [3:0] bMsb;
	} palFieldsT;

	// CPU side sees raw data, video side sees the color fields
	typedef union packed {
		logic [15:0] raw;
		palFieldsT   fields;
	} palWordT;

	// Final 7-bit color channels
	typedef struct packed {
		logic [6:0] r;
		logic [6:0] g;
		logic [6:0] b;
	} rgbT;

endpackage

`default_nettype wire

/* design/bus_decode.sv */
`timescale 1ns/100ps
`default_nettype none

`include "neo_defines.svh"

module bus_decode
	import neoPkg::*;
(
	input  logic        CLK_24M,
	input  logic        rstN,
	input  logic        cpuReq,
	input  cpuBusT      cpuBus,
	output logic        latchWr,
	output logic        palSel,
	input  logic [15:0] palRdData,
	output logic        cpuAck,
	output logic [15:0] cpuRdData
);

	// Region hits from the upper address bits
	logic latchHit;
	logic palHit;
	// Cycle in flight was a palette read
	logic ackPalRd;

	// Latch region at 0x3A0000
	assign latchHit = (cpuBus.addr[23:17] == `NEO_LATCH_BASE);

	// Palette region 0x400000 to 0x7FFFFF
	assign palHit = (cpuBus.addr[23:22] == `NEO_PAL_HI);

	// Latch is written by address only
	// Reads of the latch fall through to open bus
	assign latchWr = cpuReq & latchHit & ~cpuBus.rw;

	// Palette takes both reads and writes
	assign palSel = cpuReq & palHit;

	// Every request acknowledged exactly one cycle later
	always_ff @(posedge CLK_24M or negedge rstN) begin
		if (!rstN) begin
			cpuAck   <= 1'b0;
			ackPalRd <= 1'b0;
		end else begin
			cpuAck   <= cpuReq;
			// Remember target so read data can be steered
			ackPalRd <= palSel & cpuBus.rw;
		end
	end

	// Palette data arrives in the ack cycle
	// Anything else reads back as open bus
	assign cpuRdData = ackPalRd ? palRdData : `NEO_OPEN_BUS;

endmodule

`default_nettype wire

/* design/sys_latch.sv */
`timescale 1ns/100ps
`default_nettype none

module sys_latch (
	input  logic       CLK_24M,
	input  logic       rstN,
	input  logic       latchWr,
	// Word address bits 4 to 1
	input  logic [3:0] latchAddr,
	output logic       shadow,
	output logic       palBank
);

	// Latch bit positions
	localparam logic [2:0] ShadowIdx = 3'd0;
	localparam logic [2:0] BankIdx   = 3'd7;

	// Bit index from address bits 3 to 1
	logic [2:0] bitIdx;
	// Value from address bit 4
	logic       bitVal;

	assign bitIdx = latchAddr[2:0];
	assign bitVal = latchAddr[3];

	always_ff @(posedge CLK_24M or negedge rstN) begin
		if (!rstN) begin
			shadow  <= 1'b0;
			palBank <= 1'b0;
		end else if (latchWr) begin
			case (bitIdx)
				ShadowIdx: begin
					shadow <= bitVal;
				end
				// Bank sense inverted on the board
				// 0x3A000F selects bank 1, 0x3A001F selects bank 0
				BankIdx: begin
					palBank <= ~bitVal;
				end
				// Remaining bits not modeled
				default: begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/palette_ram.sv */
`timescale 1ns/100ps
`default_nettype none

`include "neo_defines.svh"

module palette_ram
	import neoPkg::*;
(
	input  logic                      CLK_24M,
	input  logic                      palSel,
	input  logic                      palBank,
	input  cpuBusT                    cpuBus,
	output logic [15:0]               palRdData,
	input  logic                      vidRd,
	input  logic [`NEO_PAL_IDX_W-1:0] vidIdx,
	input  logic                      vidBank,
	output palWordT                   vidData
);

	// Two banks of 4096 words
	localparam int Depth = 1 << (`NEO_PAL_IDX_W + 1);

	logic [15:0] mem [Depth];

	// Bank bit on top of the index
	logic [`NEO_PAL_IDX_W:0] cpuAddr;
	logic [`NEO_PAL_IDX_W:0] vidAddr;

	// Low word-address bits only so the region mirrors every 8 KB
	assign cpuAddr = {palBank, cpuBus.addr[`NEO_PAL_IDX_W:1]};
	assign vidAddr = {vidBank, vidIdx};

	// CPU port
	// Read first, old data returned on a write cycle
	always_ff @(posedge CLK_24M) begin
		if (palSel) begin
			palRdData <= mem[cpuAddr];
			if (!cpuBus.rw) begin
				// Byte lanes written independently
				if (cpuBus.uppEn) begin
					mem[cpuAddr][15:8] <= cpuBus.wrData[15:8];
				end
				if (cpuBus.lowEn) begin
					mem[cpuAddr][7:0] <= cpuBus.wrData[7:0];
				end
			end
		end
	end

	// Video port
	// Same-word collision sees the old value
	always_ff @(posedge CLK_24M) begin
		if (vidRd) begin
			vidData.raw <= mem[vidAddr];
		end
	end

endmodule

`default_nettype wire

/* design/video_out.sv */
`timescale 1ns/100ps
`default_nettype none

`include "neo_defines.svh"

module video_out
	import neoPkg::*;
(
	input  logic                      CLK_24M,
	input  logic                      rstN,
	input  logic                      pixValid,
	input  logic                      pixBlank,
	input  logic [`NEO_PAL_IDX_W-1:0] pixIdx,
	input  logic                      shadow,
	input  logic                      palBank,
	output logic                      vidRd,
	output logic [`NEO_PAL_IDX_W-1:0] vidIdx,
	output logic                      vidBank,
	input  palWordT                   vidData,
	output logic                      rgbValid,
	output rgbT                       rgb
);

	// Stage one pipeline state
	logic s1Valid;
	logic s1Blank;
	logic s1Shadow;
	// Stage two result before the output register
	rgbT  nextRgb;

	// MSB nibble, LSB, then two copies of inverted dark
	// Shadow halves the channel
	function automatic logic [6:0] mkChan(input logic [3:0] msb, input logic lsb,
		input logic dark, input logic shd);
		logic [6:0] chan;
		chan = {msb, lsb, ~dark, ~dark};
		return shd ? (chan >> 1) : chan;
	endfunction

	// Stage one
	// Blanked pixels skip the palette read
	assign vidRd   = pixValid & ~pixBlank;
	assign vidIdx  = pixIdx;
	// Bank taken as the pixel enters
	assign vidBank = palBank;

	always_ff @(posedge CLK_24M or negedge rstN) begin
		if (!rstN) begin
			s1Valid  <= 1'b0;
			s1Blank  <= 1'b0;
			s1Shadow <= 1'b0;
		end else begin
			s1Valid  <= pixValid;
			s1Blank  <= pixBlank;
			s1Shadow <= shadow;
		end
	end

	// Stage two decode of the palette fields
	always_comb begin
		nextRgb.r = mkChan(vidData.fields.rMsb, vidData.fields.rLsb, vidData.fields.dark, s1Shadow);
		nextRgb.g = mkChan(vidData.fields.gMsb, vidData.fields.gLsb, vidData.fields.dark, s1Shadow);
		nextRgb.b = mkChan(vidData.fields.bMsb, vidData.fields.bLsb, vidData.fields.dark, s1Shadow);
		// Blanking forces black
		if (s1Blank) begin
			nextRgb = '0;
		end
	end

	always_ff @(posedge CLK_24M or negedge rstN) begin
		if (!rstN) begin
			rgbValid <= 1'b0;
		end else begin
			rgbValid <= s1Valid;
		end
	end

	// Color held between pixels
	always_ff @(posedge CLK_24M) begin
		if (s1Valid) begin
			rgb <= nextRgb;
		end
	end

endmodule

`default_nettype wire

/* design/neo_video_sys.sv */
`timescale 1ns/100ps
`default_nettype none

`include "neo_defines.svh"

module neo_video_sys
	import neoPkg::*;
(
	input  logic                      CLK_24M,
	input  logic                      rstN,
	input  logic                      cpuReq,
	input  cpuBusT                    cpuBus,
	output logic                      cpuAck,
	output logic [15:0]               cpuRdData,
	input  logic                      pixValid,
	input  logic                      pixBlank,
	input  logic [`NEO_PAL_IDX_W-1:0] pixIdx,
	output logic                      rgbValid,
	output rgbT                       rgb
);

	// Decoder to targets
	logic                      latchWr;
	logic                      palSel;
	logic [15:0]               palRdData;
	// Latch outputs
	logic                      shadow;
	logic                      palBank;
	// Video read port
	logic                      vidRd;
	logic [`NEO_PAL_IDX_W-1:0] vidIdx;
	logic                      vidBank;
	palWordT                   vidData;

	bus_decode bus_decode_inst (
		.CLK_24M  (CLK_24M),
		.rstN     (rstN),
		.cpuReq   (cpuReq),
		.cpuBus   (cpuBus),
		.latchWr  (latchWr),
		.palSel   (palSel),
		.palRdData(palRdData),
		.cpuAck   (cpuAck),
		.cpuRdData(cpuRdData)
	);

	// Bit index and value ride on address bits 4 to 1
	sys_latch sys_latch_inst (
		.CLK_24M  (CLK_24M),
		.rstN     (rstN),
		.latchWr  (latchWr),
		.latchAddr(cpuBus.addr[4:1]),
		.shadow   (shadow),
		.palBank  (palBank)
	);

	palette_ram palette_ram_inst (
		.CLK_24M  (CLK_24M),
		.palSel   (palSel),
		.palBank  (palBank),
		.cpuBus   (cpuBus),
		.palRdData(palRdData),
		.vidRd    (vidRd),
		.vidIdx   (vidIdx),
		.vidBank  (vidBank),
		.vidData  (vidData)
	);

	video_out video_out_inst (
		.CLK_24M (CLK_24M),
		.rstN    (rstN),
		.pixValid(pixValid),
		.pixBlank(pixBlank),
		.pixIdx  (pixIdx),
		.shadow  (shadow),
		.palBank (palBank),
		.vidRd   (vidRd),
		.vidIdx  (vidIdx),
		.vidBank (vidBank),
		.vidData (vidData),
		.rgbValid(rgbValid),
		.rgb     (rgb)
	);

endmodule

`default_nettype wire

/* test/tb_neo_video_sys.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_neo_video_sys
	import neoPkg::*;
;

	// Length of the tests in clocks, two clocks per bus cycle
	// Reset and the closing idle cycles on top
	localparam int BusOps       = 52;
	localparam int StreamCycles = 52;
	localparam int TestLen      = 5 + 2 * BusOps + StreamCycles;
	localparam int CycleLimit   = 2 * TestLen;

	logic        CLK_24M;
	logic        rstN;
	logic        cpuReq;
	cpuBusT      cpuBus;
	logic        cpuAck;
	logic [15:0] cpuRdData;
	logic        pixValid;
	logic        pixBlank;
	logic [11:0] pixIdx;
	logic        rgbValid;
	rgbT         rgb;

	// Reference state: palette contents and latch bits
	logic [15:0] palModel [8192];
	logic        tbShadow;
	logic        tbBank;
	logic [11:0] tblIdx [16];
	logic [11:0] streamIdx [$];
	logic        streamBlank [$];
	logic [31:0] rngState;
	int          errors;
	int          cycleCnt;

	neo_video_sys neo_video_sys_inst (
		.CLK_24M  (CLK_24M),
		.rstN     (rstN),
		.cpuReq   (cpuReq),
		.cpuBus   (cpuBus),
		.cpuAck   (cpuAck),
		.cpuRdData(cpuRdData),
		.pixValid (pixValid),
		.pixBlank (pixBlank),
		.pixIdx   (pixIdx),
		.rgbValid (rgbValid),
		.rgb      (rgb)
	);

	always #4 CLK_24M = ~CLK_24M;

	// Hard stop if something stalls
	always @(posedge CLK_24M) begin
		cycleCnt <= cycleCnt + 1;
		if (cycleCnt >= CycleLimit) begin
			$display("Timeout: run did not finish within %0d cycles", CycleLimit);
			$display("Verification failed");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Byte address in palette space for an index
	function automatic logic [23:0] palAddr(input logic [11:0] idx);
		return {11'b010_0000_0000, idx, 1'b0};
	endfunction

	// Channel = MSB nibble, LSB, two copies of inverted dark
	function automatic logic [20:0] expRgb(input logic [15:0] w, input logic shd,
		input logic blk);
		logic [6:0] r;
		logic [6:0] g;
		logic [6:0] b;
		r = {w[11:8], w[14], ~w[15], ~w[15]};
		g = {w[7:4], w[13], ~w[15], ~w[15]};
		b = {w[3:0], w[12], ~w[15], ~w[15]};
		if (shd) begin
			r = r >> 1;
			g = g >> 1;
			b = b >> 1;
		end
		return blk ? 21'h0 : {r, g, b};
	endfunction

	task automatic checkVal(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("ERROR %s expected %h got %h at %0t", name, exp, act, $time);
			errors++;
		end
	endtask

	// One request, then wait for the ack and idle a cycle after it
	task automatic busCycle(input logic [23:0] byteAddr, input logic rw, input logic [15:0] data,
		input logic upp, input logic low, output logic [15:0] rd);
		int waitCnt;
		cpuReq        = 1'b1;
		cpuBus.addr   = byteAddr[23:1];
		cpuBus.wrData = data;
		cpuBus.rw     = rw;
		cpuBus.uppEn  = upp;
		cpuBus.lowEn  = low;
		@(posedge CLK_24M);
		#1;
		cpuReq  = 1'b0;
		waitCnt = 1;
		while (!cpuAck && waitCnt < 8) begin
			@(posedge CLK_24M);
			#1;
			waitCnt++;
		end
		if (!cpuAck) begin
			$display("No acknowledge seen for bus cycle at address %h", byteAddr);
			errors++;
		end else begin
			checkVal("ackLatency", 1, waitCnt);
		end
		rd = cpuRdData;
		@(posedge CLK_24M);
		#1;
		// Ack is a single-cycle pulse
		checkVal("cpuAck", 0, cpuAck);
	endtask

	task automatic cpuWrite(input logic [23:0] a, input logic [15:0] d, input logic upp,
		input logic low);
		logic [15:0] rd;
		logic [12:0] mIdx;
		busCycle(a, 1'b0, d, upp, low, rd);
		mIdx = {tbBank, a[12:1]};
		if (a[23:22] == 2'b01) begin
			if (upp) palModel[mIdx][15:8] = d[15:8];
			if (low) palModel[mIdx][7:0] = d[7:0];
		end else if (a[23:17] == 7'h1D) begin
			// Index in bits 3 to 1, value in bit 4
			if (a[3:1] == 3'd0) tbShadow = a[4];
			else if (a[3:1] == 3'd7) tbBank = ~a[4];
		end
	endtask

	task automatic cpuRead(input logic [23:0] a);
		logic [15:0] rd;
		logic [15:0] exp;
		busCycle(a, 1'b1, 16'h0, 1'b1, 1'b1, rd);
		exp = (a[23:22] == 2'b01) ? palModel[{tbBank, a[12:1]}] : 16'hFFFF;
		checkVal("cpuRdData", exp, rd);
	endtask

	// Push queued pixels back to back, output checked two cycles behind
	task automatic runStream;
		logic [20:0] expQ [$];
		int n;
		n = streamIdx.size();
		for (int j = 0; j <= n + 1; j++) begin
			if (j < n) begin
				pixValid = 1'b1;
				pixBlank = streamBlank[j];
				pixIdx   = streamIdx[j];
				expQ.push_back(expRgb(palModel[{tbBank, streamIdx[j]}], tbShadow, streamBlank[j]));
			end else begin
				pixValid = 1'b0;
				pixBlank = 1'b0;
			end
			@(posedge CLK_24M);
			#1;
			if (j >= 1 && j <= n) begin
				checkVal("rgbValid", 1, rgbValid);
				checkVal("rgb", expQ.pop_front(), rgb);
			end else begin
				checkVal("rgbValid", 0, rgbValid);
			end
		end
		streamIdx.delete();
		streamBlank.delete();
	endtask

	task automatic testBasicRw;
		logic [11:0] idx [6];
		for (int i = 0; i < 6; i++) begin
			rngState = xorshift(rngState);
			idx[i]   = rngState[11:0];
			rngState = xorshift(rngState);
			cpuWrite(palAddr(idx[i]), rngState[15:0], 1'b1, 1'b1);
		end
		for (int i = 0; i < 6; i++) cpuRead(palAddr(idx[i]));
		// Unmapped write with a palette offset is dropped
		cpuWrite(24'h100000 | {11'h0, idx[0], 1'b0}, 16'h1234, 1'b1, 1'b1);
		cpuRead(palAddr(idx[0]));
		// Latch read with the value bit set must leave shadow alone
		cpuRead(24'h3A0010);
		cpuRead(24'h200000);
		cpuRead(24'hC00000);
	endtask

	task automatic testByteLanes;
		logic [11:0] idx;
		rngState = xorshift(rngState);
		idx      = rngState[11:0];
		cpuWrite(palAddr(idx), 16'h1234, 1'b1, 1'b1);
		cpuWrite(palAddr(idx), 16'hABCD, 1'b1, 1'b0);
		cpuRead(palAddr(idx));
		cpuWrite(palAddr(idx), 16'h5678, 1'b0, 1'b1);
		cpuRead(palAddr(idx));
		// 8 KB mirrors hit the same word
		cpuWrite(palAddr(idx) + 24'h2000, 16'h9ABC, 1'b1, 1'b1);
		cpuRead(palAddr(idx));
		cpuWrite(palAddr(idx) | 24'h200000, 16'h0F1E, 1'b1, 1'b1);
		cpuRead(palAddr(idx) | 24'h3FE000);
	endtask

	task automatic testBanks;
		logic [11:0] idx;
		logic [15:0] dA;
		rngState = xorshift(rngState);
		idx      = rngState[11:0];
		dA       = rngState[31:16];
		cpuWrite(24'h3A000F, 16'h0, 1'b1, 1'b1);
		cpuWrite(palAddr(idx), dA, 1'b1, 1'b1);
		cpuWrite(24'h3A001F, 16'h0, 1'b1, 1'b1);
		cpuWrite(palAddr(idx), ~dA, 1'b1, 1'b1);
		cpuRead(palAddr(idx));
		streamIdx.push_back(idx);
		streamBlank.push_back(1'b0);
		runStream();
		cpuWrite(24'h3A000F, 16'h0, 1'b1, 1'b1);
		cpuRead(palAddr(idx));
		streamIdx.push_back(idx);
		streamBlank.push_back(1'b0);
		runStream();
		cpuWrite(24'h3A001F, 16'h0, 1'b1, 1'b1);
	endtask

	task automatic testPixelStream;
		for (int i = 0; i < 16; i++) begin
			rngState  = xorshift(rngState);
			tblIdx[i] = rngState[11:0];
			rngState  = xorshift(rngState);
			cpuWrite(palAddr(tblIdx[i]), rngState[15:0], 1'b1, 1'b1);
		end
		for (int i = 0; i < 24; i++) begin
			rngState = xorshift(rngState);
			streamIdx.push_back(tblIdx[rngState[3:0]]);
			streamBlank.push_back(1'b0);
		end
		runStream();
	endtask

	task automatic testShadowBlank;
		// Index 0 with value bit set turns shadow on
		cpuWrite(24'h3A0010, 16'h0, 1'b1, 1'b1);
		for (int i = 0; i < 8; i++) begin
			streamIdx.push_back(tblIdx[i]);
			streamBlank.push_back(i % 3 == 2);
		end
		runStream();
		cpuWrite(24'h3A0000, 16'h0, 1'b1, 1'b1);
		for (int i = 0; i < 8; i++) begin
			streamIdx.push_back(tblIdx[i + 8]);
			streamBlank.push_back(i % 3 == 0);
		end
		runStream();
	endtask

	initial begin
		CLK_24M  = 1'b0;
		rstN     = 1'b0;
		cpuReq   = 1'b0;
		cpuBus   = '0;
		pixValid = 1'b0;
		pixBlank = 1'b0;
		pixIdx   = '0;
		tbShadow = 1'b0;
		tbBank   = 1'b0;
		rngState = 32'h29;
		errors   = 0;
		cycleCnt = 0;
		repeat (3) @(posedge CLK_24M);
		#1;
		rstN = 1'b1;
		checkVal("cpuAck", 0, cpuAck);
		checkVal("rgbValid", 0, rgbValid);
		testBasicRw();
		testByteLanes();
		testBanks();
		testPixelStream();
		testShadowBlank();
		repeat (2) @(posedge CLK_24M);
		$display("Finished with %0d errors", errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
+incdir+design
design/neo_pkg.sv
design/bus_decode.sv
design/sys_latch.sv
design/palette_ram.sv
design/video_out.sv
design/neo_video_sys.sv
test/tb_neo_video_sys.sv

/* Bender.yml */
package:
  name: neo_video_sys

sources:
  - include_dirs:
      - design
    files:
      - design/neo_pkg.sv
      - design/bus_decode.sv
      - design/sys_latch.sv
      - design/palette_ram.sv
      - design/video_out.sv
      - design/neo_video_sys.sv
  - target: test
    files:
      - test/tb_neo_video_sys.sv
